// ==== logic/div_pkg.sv ====
// divider shared definitions
// widths, function codes, step count and control states

package div_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // operand width
  localparam int DATA_W = 32;

  // one quotient bit per iteration
  localparam int DIV_STEPS = 32;

  // ------------------------------
  // request function codes
  // ------------------------------

  localparam logic FN_UNSIGNED = 1'b0;
  localparam logic FN_SIGNED   = 1'b1;

  // ------------------------------
  // types
  // ------------------------------

  // operand, quotient or remainder
  typedef logic [DATA_W-1:0] data_t;

  // response word, remainder high and quotient low
  typedef logic [2*DATA_W-1:0] result_t;

  // guard bit + remainder + quotient bits
  typedef logic [2*DATA_W:0] prem_t;

  // counts 0 .. DIV_STEPS+1
  typedef logic [5:0] count_t;

  // control states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CALC,
    ST_FIX,
    ST_DONE
  } ctrl_state_t;

endpackage

// ==== logic/div_ctrl.sv ====
// divider control FSM
// sequences load, init, 32 steps and sign fix, owns the handshakes

module div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic init,
  output logic step,
  output logic fix
);

  div_pkg::ctrl_state_t state;
  div_pkg::count_t      count;

  // ------------------------------
  // state and counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::ST_IDLE;
      count <= '0;
    end else begin
      case (state)
        div_pkg::ST_IDLE: begin
          // counter restarts for every accepted request
          count <= '0;
          if (load) begin
            state <= div_pkg::ST_CALC;
          end
        end
        div_pkg::ST_CALC: begin
          // count 0 is the init cycle, 1..DIV_STEPS are steps
          count <= count + 6'd1;
          if (count == div_pkg::count_t'(div_pkg::DIV_STEPS)) begin
            state <= div_pkg::ST_FIX;
          end
        end
        div_pkg::ST_FIX: begin
          // count sits at DIV_STEPS+1 here
          state <= div_pkg::ST_DONE;
        end
        div_pkg::ST_DONE: begin
          // hold response until taken
          if (resp_rdy) begin
            state <= div_pkg::ST_IDLE;
          end
        end
        default: begin
          state <= div_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    init     = 1'b0;
    step     = 1'b0;
    fix      = 1'b0;
    case (state)
      div_pkg::ST_IDLE: begin
        req_rdy = 1'b1;
      end
      div_pkg::ST_CALC: begin
        // first calc cycle seeds the partial remainder
        if (count == '0) begin
          init = 1'b1;
        end else begin
          step = 1'b1;
        end
      end
      div_pkg::ST_FIX: begin
        fix = 1'b1;
      end
      div_pkg::ST_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // one-cycle pulse at the acceptance edge
  assign load = req_rdy && req_val;

endmodule

// ==== logic/div_operand_stage.sv ====
// divider operand stage
// holds the request, forms magnitudes and result sign flags

module div_operand_stage (
  input  logic          clk,
  input  logic          reset,
  input  logic          load,
  input  logic          req_fn,
  input  div_pkg::data_t req_a,
  input  div_pkg::data_t req_b,
  output div_pkg::data_t dividend_mag,
  output div_pkg::data_t divisor_mag,
  output logic          neg_quot,
  output logic          neg_rem
);

  logic           fn_reg;
  div_pkg::data_t a_reg;
  div_pkg::data_t b_reg;
  logic           a_neg;
  logic           b_neg;

  // ------------------------------
  // request capture
  // ------------------------------

  // function bit decides sign handling
  always_ff @(posedge clk) begin
    if (reset) begin
      fn_reg <= div_pkg::FN_UNSIGNED;
    end else if (load) begin
      fn_reg <= req_fn;
    end
  end

  // operands
  always_ff @(posedge clk) begin
    if (load) begin
      a_reg <= req_a;
      b_reg <= req_b;
    end
  end

  // ------------------------------
  // magnitudes
  // ------------------------------

  // sign bits only count in signed mode
  assign a_neg = (fn_reg == div_pkg::FN_SIGNED) && a_reg[div_pkg::DATA_W-1];
  assign b_neg = (fn_reg == div_pkg::FN_SIGNED) && b_reg[div_pkg::DATA_W-1];

  // two's complement of negative operands
  // most negative value maps onto itself, read as unsigned 2^31
  assign dividend_mag = a_neg ? (~a_reg + 1'b1) : a_reg;
  assign divisor_mag  = b_neg ? (~b_reg + 1'b1) : b_reg;

  // quotient negative when exactly one operand is
  assign neg_quot = a_neg ^ b_neg;

  // remainder follows the dividend
  assign neg_rem = a_neg;

endmodule

// ==== logic/div_restoring_step.sv ====
// restoring divider iteration
// one shift-subtract-restore per cycle on a 65-bit partial remainder

module div_restoring_step (
  input  logic           clk,
  input  logic           reset,
  input  logic           init,
  input  logic           step,
  input  div_pkg::data_t dividend_mag,
  input  div_pkg::data_t divisor_mag,
  output div_pkg::data_t quotient_mag,
  output div_pkg::data_t remainder_mag
);

  localparam int W = div_pkg::DATA_W;

  // upper W+1 bits remainder with guard, lower W bits quotient
  div_pkg::prem_t prem;
  div_pkg::prem_t shifted;
  logic [W:0]     trial;
  div_pkg::prem_t next_prem;

  // ------------------------------
  // one iteration
  // ------------------------------

  // shift in the next dividend bit
  assign shifted = {prem[2*W-1:0], 1'b0};

  // trial subtract on the upper part
  assign trial = shifted[2*W:W] - {1'b0, divisor_mag};

  always_comb begin
    if (!trial[W]) begin
      // fits, keep difference and set quotient bit
      next_prem = {trial, shifted[W-1:1], 1'b1};
    end else begin
      // restore, quotient bit stays zero
      next_prem = shifted;
    end
  end

  // ------------------------------
  // partial remainder register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      prem <= '0;
    end else if (init) begin
      // dividend magnitude starts in the low half
      prem <= {{(W+1){1'b0}}, dividend_mag};
    end else if (step) begin
      prem <= next_prem;
    end
  end

  // guard bit is always clear after the last step
  assign quotient_mag  = prem[W-1:0];
  assign remainder_mag = prem[2*W-1:W];

endmodule

// ==== logic/div_result_sign.sv ====
// divider sign fix stage
// applies result signs and holds the response word

module div_result_sign (
  input  logic            clk,
  input  logic            reset,
  input  logic            fix,
  input  div_pkg::data_t  quotient_mag,
  input  div_pkg::data_t  remainder_mag,
  input  logic            neg_quot,
  input  logic            neg_rem,
  output div_pkg::result_t resp_result
);

  div_pkg::data_t quot_signed;
  div_pkg::data_t rem_signed;

  // ------------------------------
  // sign application
  // ------------------------------

  // negate where flagged
  assign quot_signed = neg_quot ? (~quotient_mag + 1'b1) : quotient_mag;
  assign rem_signed  = neg_rem ? (~remainder_mag + 1'b1) : remainder_mag;

  // ------------------------------
  // response register
  // ------------------------------

  // loads once per division, stable through any stall
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_result <= '0;
    end else if (fix) begin
      // remainder high, quotient low
      resp_result <= {rem_signed, quot_signed};
    end
  end

endmodule

// ==== logic/div_unit.sv ====
// iterative 32-bit integer divider
// valid/ready request and response ports around control and datapath

module div_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             req_fn,
  input  div_pkg::data_t   req_a,
  input  div_pkg::data_t   req_b,
  input  logic             req_val,
  output logic             req_rdy,
  output div_pkg::result_t resp_result,
  output logic             resp_val,
  input  logic             resp_rdy
);

  // control to datapath
  logic load;
  logic init;
  logic step;
  logic fix;

  // operand stage to iteration and sign fix
  div_pkg::data_t dividend_mag;
  div_pkg::data_t divisor_mag;
  logic           neg_quot;
  logic           neg_rem;

  // iteration to sign fix
  div_pkg::data_t quotient_mag;
  div_pkg::data_t remainder_mag;

  // ------------------------------
  // control
  // ------------------------------

  div_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .load     (load),
    .init     (init),
    .step     (step),
    .fix      (fix)
  );

  // ------------------------------
  // datapath
  // ------------------------------

  div_operand_stage opnd (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .req_fn       (req_fn),
    .req_a        (req_a),
    .req_b        (req_b),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag),
    .neg_quot     (neg_quot),
    .neg_rem      (neg_rem)
  );

  div_restoring_step iter (
    .clk           (clk),
    .reset         (reset),
    .init          (init),
    .step          (step),
    .dividend_mag  (dividend_mag),
    .divisor_mag   (divisor_mag),
    .quotient_mag  (quotient_mag),
    .remainder_mag (remainder_mag)
  );

  div_result_sign fixup (
    .clk           (clk),
    .reset         (reset),
    .fix           (fix),
    .quotient_mag  (quotient_mag),
    .remainder_mag (remainder_mag),
    .neg_quot      (neg_quot),
    .neg_rem       (neg_rem),
    .resp_result   (resp_result)
  );

endmodule

// ==== tb/div_properties.sv ====
// divider handshake assertions
// bound into div_unit, covers stall hold, ready exclusion and latency

module div_properties (
  input logic             clk,
  input logic             reset,
  input logic             req_val,
  input logic             req_rdy,
  input logic             resp_val,
  input logic             resp_rdy,
  input div_pkg::result_t resp_result
);

  // acceptance edge to resp_val rising
  localparam int LATENCY = 34;

  // ------------------------------
  // response side
  // ------------------------------

  // stalled response holds value and valid
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result))
    else $error("response changed while stalled");

  // idle and done never overlap
  rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // resp_val goes high at the 34th edge after acceptance,
  // so sampling first sees it one tick later
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |=> !resp_val [*LATENCY] ##1 resp_val)
    else $error("resp_val did not rise 34 cycles after acceptance");

  // reset clears the response
  reset_clear: assert property (@(posedge clk)
    reset |=> !resp_val)
    else $error("resp_val high after reset");

endmodule

bind div_unit div_properties props0 (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

// ==== tb/div_tb.sv ====
// testbench for the iterative divider
// directed, corner and random divisions with response stalls

module div_tb;

  localparam int PERIOD       = 40;
  localparam int LATENCY      = 34;
  localparam int MAX_STALL    = 7;
  localparam int NUM_DIRECTED = 14;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM;
  // a few extra cycles for reset
  localparam int TIMEOUT_CYCLES = NUM_OPS * (LATENCY + MAX_STALL + 4) + 10;

  logic             clk;
  logic             reset;
  logic             req_fn;
  div_pkg::data_t   req_a;
  div_pkg::data_t   req_b;
  logic             req_val;
  logic             req_rdy;
  div_pkg::result_t resp_result;
  logic             resp_val;
  logic             resp_rdy;

  // expected responses, oldest first
  div_pkg::result_t exp_q[$];
  integer seed;
  int     errors      = 0;
  int     resp_count  = 0;
  int     rise_cycles;
  logic   busy        = 1'b0;
  logic   ready_due   = 1'b0;
  logic   resp_val_q  = 1'b0;
  time    accept_time = 0;

  div_unit dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #(PERIOD / 2) clk = ~clk;

  // ------------------------------
  // reference model
  // ------------------------------

  // remainder high, quotient low
  function automatic div_pkg::result_t expected_result(input logic fn,
                                                       input div_pkg::data_t a,
                                                       input div_pkg::data_t b);
    logic           a_neg;
    logic           b_neg;
    div_pkg::data_t a_abs;
    div_pkg::data_t b_abs;
    div_pkg::data_t q;
    div_pkg::data_t r;
    a_neg = (fn == div_pkg::FN_SIGNED) && a[div_pkg::DATA_W-1];
    b_neg = (fn == div_pkg::FN_SIGNED) && b[div_pkg::DATA_W-1];
    a_abs = a_neg ? -a : a;
    b_abs = b_neg ? -b : b;
    if (b_abs == '0) begin
      // no trap, all-ones quotient and dividend as remainder
      q = '1;
      r = a_abs;
    end else begin
      // most negative by minus one wraps here on its own
      q = a_abs / b_abs;
      r = a_abs % b_abs;
    end
    if (a_neg ^ b_neg) begin
      q = -q;
    end
    if (a_neg) begin
      r = -r;
    end
    return {r, q};
  endfunction

  // ------------------------------
  // monitors and checker
  // ------------------------------

  // request side, push expectation at acceptance
  always @(posedge clk) begin
    if (!reset) begin
      if (busy && req_rdy) begin
        errors++;
        $display("req_rdy went high while a division was in flight");
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        busy = 1'b1;
        accept_time = $time;
      end
    end
  end

  // response side, compare every valid cycle, pop at handshake
  always @(posedge clk) begin
    if (!reset) begin
      if (ready_due && !req_rdy) begin
        errors++;
        $display("req_rdy not back high the cycle after a response");
      end
      ready_due = 1'b0;
      if (resp_val && !resp_val_q) begin
        // sampled one edge after the rise
        rise_cycles = int'(($time - accept_time) / PERIOD) - 1;
        if (rise_cycles != LATENCY) begin
          errors++;
          $display("FAIL resp_val latency expected %h got %h", LATENCY, rise_cycles);
        end
      end
      if (resp_val) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response valid with no request outstanding");
        end else begin
          if (resp_result !== exp_q[0]) begin
            errors++;
            $display("FAIL resp_result expected %h got %h", exp_q[0], resp_result);
          end
          if (resp_rdy) begin
            void'(exp_q.pop_front());
            busy = 1'b0;
            ready_due = 1'b1;
            resp_count++;
          end
        end
      end
    end
    resp_val_q = resp_val;
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  // one division, resp_rdy held low for stall cycles once valid
  task automatic run_op(input logic fn, input div_pkg::data_t a,
                        input div_pkg::data_t b, input int stall);
    @(negedge clk);
    req_fn   = fn;
    req_a    = a;
    req_b    = b;
    req_val  = 1'b1;
    resp_rdy = (stall == 0);
    @(posedge clk);
    while (!req_rdy) begin
      @(posedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;
    while (!resp_val) begin
      @(negedge clk);
    end
    repeat (stall) @(negedge clk);
    resp_rdy = 1'b1;
    @(posedge clk);
  endtask

  initial begin
    logic           fn;
    div_pkg::data_t a;
    div_pkg::data_t b;
    div_pkg::data_t rnd;
    int             stall;
    seed     = 32'h0a03d4e9;
    clk      = 1'b0;
    reset    = 1'b1;
    req_fn   = div_pkg::FN_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    if (resp_val !== 1'b0 || req_rdy !== 1'b1) begin
      errors++;
      $display("handshake outputs wrong after reset");
    end

    // unsigned directed
    run_op(div_pkg::FN_UNSIGNED, 32'd100, 32'd7, 0);
    run_op(div_pkg::FN_UNSIGNED, 32'd3, 32'd10, 0);
    run_op(div_pkg::FN_UNSIGNED, 32'd12345, 32'd12345, 0);
    run_op(div_pkg::FN_UNSIGNED, 32'hdeadbeef, 32'd1, 0);
    run_op(div_pkg::FN_UNSIGNED, 32'hffffffff, 32'h10, 0);
    // signed, all four sign pairs
    run_op(div_pkg::FN_SIGNED, 32'sd100, 32'sd7, 0);
    run_op(div_pkg::FN_SIGNED, -32'sd100, 32'sd7, 0);
    run_op(div_pkg::FN_SIGNED, 32'sd100, -32'sd7, 0);
    run_op(div_pkg::FN_SIGNED, -32'sd100, -32'sd7, 0);
    // divide by zero and overflow
    run_op(div_pkg::FN_UNSIGNED, 32'h1234, 32'd0, 0);
    run_op(div_pkg::FN_SIGNED, -32'sd5, 32'd0, 0);
    run_op(div_pkg::FN_SIGNED, 32'h12345678, 32'd0, 0);
    run_op(div_pkg::FN_SIGNED, 32'h80000000, 32'hffffffff, 0);
    run_op(div_pkg::FN_UNSIGNED, 32'h80000000, 32'hffffffff, 0);

    // random operations with stalls
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd = $random(seed);
      fn = rnd[0];
      a = $random(seed);
      b = $random(seed);
      // shorter divisors give wider quotients
      b = b >> rnd[8:4];
      stall = $unsigned($random(seed)) % (MAX_STALL + 1);
      run_op(fn, a, b, stall);
    end

    repeat (2) @(negedge clk);
    if (exp_q.size() != 0 || resp_count != NUM_OPS) begin
      errors++;
      $display("responses missing, %0d of %0d received", resp_count, NUM_OPS);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // ------------------------------
  // watchdog
  // ------------------------------

  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("timeout, divider stopped responding after %0d responses, errors: %0d",
             resp_count, errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
logic/div_pkg.sv
logic/div_ctrl.sv
logic/div_operand_stage.sv
logic/div_restoring_step.sv
logic/div_result_sign.sv
logic/div_unit.sv
tb/div_properties.sv
tb/div_tb.sv
